// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_pe_top with Verilator, run it, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_pe_top \
		-f pe_top.f -Mdir obj_dir -o sim_pe
	./obj_dir/sim_pe | tee sim.log
	@grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/tb_pe_top.sv
module tb_pe_top;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int REG_NUM = 8;
   localparam int OUT_NUM = 4;

   // register map
   localparam logic [7:0] A_ITER   = 8'h00;
   localparam logic [7:0] A_ICNT   = 8'h04;
   localparam logic [7:0] A_STATUS = 8'h08;
   localparam logic [7:0] A_PROG   = 8'h40;

   logic             clk = 1'b0;
   logic             rst;
   pe_pkg::apb_req_t apb_req;
   pe_pkg::apb_rsp_t apb_rsp;
   logic             din_v;
   pe_pkg::cplx_t    din;
   logic             dout_v;
   pe_pkg::cplx_t    dout;

   integer seed;
   int     errors;
   int     checks;
   // finished output streams seen so far
   int     runs_done;

   // stimulus and reference state
   pe_pkg::cplx_t  samples [REG_NUM];
   pe_pkg::cplx_t  model_regs [REG_NUM];
   pe_pkg::instr_t prog_copy [16];
   pe_pkg::cplx_t  out_words [OUT_NUM];

   pe_top #(
      .REG_NUM (REG_NUM),
      .OUT_NUM (OUT_NUM)
   ) dut (
      .clk     (clk),
      .rst     (rst),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp),
      .din_v   (din_v),
      .din     (din),
      .dout_v  (dout_v),
      .dout    (dout)
   );

   // 10 ns clock
   always #5 clk = ~clk;

   //////////////////////////////////////////////////////////////////////
   // checking and bookkeeping
   //////////////////////////////////////////////////////////////////////

   task automatic check_word(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
      checks++;
      if (got !== expected) begin
         errors++;
         $display("FAILED t=%0t %s expected 0x%08h got 0x%08h", $time, what, expected, got);
      end
   endtask

   // stalled handshake or stream
   task automatic abort_run(input string why);
      errors++;
      $display("%s at t=%0t", why, $time);
      $display("checks %0d errors %0d", checks, errors);
      $display("TESTBENCH FAILED");
      $finish;
   endtask

   // opcode 11:9, dst 8:6, src_a 5:3, src_b 2:0
   function automatic logic [31:0] encode_instr(input logic [2:0] op, input logic [2:0] dst,
                                                input logic [2:0] src_a,
                                                input logic [2:0] src_b);
      return {20'd0, op, dst, src_a, src_b};
   endfunction

   //////////////////////////////////////////////////////////////////////
   // APB driver
   //////////////////////////////////////////////////////////////////////

   // setup on one falling edge and access on the next
   // response sampled 1 ns into the access phase
   task automatic apb_transfer(input logic write, input logic [7:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
      int wait_cnt;
      wait_cnt = 0;
      @(negedge clk);
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = write;
      apb_req.paddr   = addr;
      apb_req.pwdata  = wdata;
      @(negedge clk);
      apb_req.penable = 1'b1;
      #1;
      while (!apb_rsp.pready) begin
         wait_cnt++;
         if (wait_cnt > 16) begin
            abort_run("APB slave never raised pready");
         end
         @(negedge clk);
         #1;
      end
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      // access completes on the rising edge in between
      @(negedge clk);
      apb_req = '0;
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                            output logic err);
      logic [31:0] unused;
      apb_transfer(1'b1, addr, data, unused, err);
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                           output logic err);
      apb_transfer(1'b0, addr, 32'd0, data, err);
   endtask

   task automatic write_program(input int idx, input logic [31:0] word);
      logic err;
      apb_write(A_PROG + 8'(4 * idx), word, err);
      check_word($sformatf("pslverr prog[%0d] write", idx), err, 0);
      prog_copy[idx] = pe_pkg::instr_t'(word[11:0]);
   endtask

   task automatic configure_run(input int iters, input int icnt);
      logic err;
      apb_write(A_ITER, iters, err);
      check_word("pslverr ITER write", err, 0);
      apb_write(A_ICNT, icnt, err);
      check_word("pslverr ICNT write", err, 0);
   endtask

   //////////////////////////////////////////////////////////////////////
   // stream driver and monitor
   //////////////////////////////////////////////////////////////////////

   task automatic random_samples();
      logic [31:0] rnd;
      for (int i = 0; i < REG_NUM; i++) begin
         rnd        = $random(seed);
         samples[i] = rnd;
      end
   endtask

   // one word per cycle with a gap before word 3
   task automatic load_samples();
      for (int i = 0; i < REG_NUM; i++) begin
         if (i == 3) begin
            @(negedge clk);
            din_v = 1'b0;
         end
         @(negedge clk);
         din_v = 1'b1;
         din   = samples[i];
      end
      @(negedge clk);
      din_v = 1'b0;
      din   = '0;
      for (int i = 0; i < REG_NUM; i++) begin
         model_regs[i] = samples[i];
      end
   endtask

   task automatic collect_output();
      int wait_cnt;
      wait_cnt = 0;
      @(negedge clk);
      while (!dout_v) begin
         wait_cnt++;
         if (wait_cnt > 4000) begin
            abort_run("timeout waiting for dout_v");
         end
         @(negedge clk);
      end
      // words must come back to back
      for (int i = 0; i < OUT_NUM; i++) begin
         if (!dout_v) begin
            errors++;
            $display("dout_v went low before output word %0d at t=%0t", i, $time);
         end
         out_words[i] = dout;
         @(negedge clk);
      end
      if (dout_v) begin
         errors++;
         $display("dout_v still high after %0d words at t=%0t", OUT_NUM, $time);
      end
      runs_done++;
   endtask

   task automatic check_outputs(input string tag);
      for (int i = 0; i < OUT_NUM; i++) begin
         check_word($sformatf("%s dout word %0d", tag, i), out_words[i], model_regs[i]);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////////////////////////

   task automatic run_model(input int iters, input int icnt);
      pe_pkg::instr_t ins;
      pe_pkg::cplx_t  a;
      pe_pkg::cplx_t  b;
      pe_pkg::cplx_t  res;
      longint         prod_re;
      longint         prod_im;
      for (int it = 0; it < iters; it++) begin
         for (int p = 0; p < icnt; p++) begin
            ins = prog_copy[p];
            a   = model_regs[ins.src_a];
            b   = model_regs[ins.src_b];
            case (ins.opcode)
               pe_pkg::OP_MOV: model_regs[ins.dst] = a;
               pe_pkg::OP_ADD: begin
                  res.re = a.re + b.re;
                  res.im = a.im + b.im;
                  model_regs[ins.dst] = res;
               end
               pe_pkg::OP_SUB: begin
                  res.re = a.re - b.re;
                  res.im = a.im - b.im;
                  model_regs[ins.dst] = res;
               end
               pe_pkg::OP_MUL: begin
                  // exact product then Q1.15 rescale and keep low 16
                  prod_re = longint'(a.re) * longint'(b.re) - longint'(a.im) * longint'(b.im);
                  prod_im = longint'(a.re) * longint'(b.im) + longint'(a.im) * longint'(b.re);
                  res.re  = 16'(prod_re >>> pe_pkg::FRAC_BITS);
                  res.im  = 16'(prod_im >>> pe_pkg::FRAC_BITS);
                  model_regs[ins.dst] = res;
               end
               // nop and codes 5 to 7
               default: ;
            endcase
         end
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // directed tests
   //////////////////////////////////////////////////////////////////////

   task automatic reset_and_register_access();
      logic [31:0] rd;
      logic        err;
      apb_read(A_STATUS, rd, err);
      check_word("STATUS after reset", rd, 0);
      check_word("pslverr STATUS read", err, 0);
      apb_read(A_ITER, rd, err);
      check_word("ITER after reset", rd, 0);
      apb_read(A_ICNT, rd, err);
      check_word("ICNT after reset", rd, 0);
      configure_run(8'h5a, 9);
      apb_read(A_ITER, rd, err);
      check_word("ITER readback", rd, 32'h5a);
      apb_read(A_ICNT, rd, err);
      check_word("ICNT readback", rd, 9);
      write_program(15, encode_instr(pe_pkg::OP_SUB, 3'd3, 3'd2, 3'd1));
      apb_read(A_PROG + 8'h3c, rd, err);
      check_word("prog[15] readback", rd, encode_instr(pe_pkg::OP_SUB, 3'd3, 3'd2, 3'd1));
      // status is read only
      apb_write(A_STATUS, 32'hffff_ffff, err);
      check_word("pslverr STATUS write", err, 1);
      apb_read(A_STATUS, rd, err);
      check_word("STATUS after rejected write", rd, 0);
      apb_read(8'h20, rd, err);
      check_word("pslverr read 0x20", err, 1);
   endtask

   task automatic basic_alu_program();
      random_samples();
      write_program(0, encode_instr(pe_pkg::OP_MOV, 3'd0, 3'd7, 3'd0));
      write_program(1, encode_instr(pe_pkg::OP_ADD, 3'd1, 3'd4, 3'd5));
      // reads r1 as just written
      write_program(2, encode_instr(pe_pkg::OP_SUB, 3'd2, 3'd6, 3'd1));
      write_program(3, encode_instr(pe_pkg::OP_NOP, 3'd3, 3'd0, 3'd1));
      configure_run(1, 4);
      load_samples();
      run_model(1, 4);
      collect_output();
      check_outputs("basic");
      check_word("nop leaves r3", out_words[3], samples[3]);
   endtask

   task automatic multiply_corners();
      random_samples();
      // -1.0 squared wraps back to -1.0
      samples[4] = 32'h8000_0000;
      samples[5] = 32'h8000_0000;
      // re cancels while im is 2.0 and truncates to 0
      samples[6] = 32'h8000_8000;
      samples[7] = 32'h8000_8000;
      write_program(0, encode_instr(pe_pkg::OP_MUL, 3'd0, 3'd4, 3'd5));
      write_program(1, encode_instr(pe_pkg::OP_MUL, 3'd1, 3'd6, 3'd7));
      write_program(2, encode_instr(pe_pkg::OP_MUL, 3'd2, 3'd2, 3'd3));
      write_program(3, encode_instr(pe_pkg::OP_MUL, 3'd3, 3'd3, 3'd0));
      configure_run(1, 4);
      load_samples();
      run_model(1, 4);
      collect_output();
      check_outputs("mul");
      check_word("mul corner r0", out_words[0], 32'h8000_0000);
      check_word("mul corner r1", out_words[1], 32'h0000_0000);
   endtask

   task automatic repeated_accumulate();
      logic [31:0] rd;
      logic        err;
      logic [15:0] exp_re;
      logic [15:0] exp_im;
      int          iters;
      iters = 9;
      random_samples();
      write_program(0, encode_instr(pe_pkg::OP_ADD, 3'd0, 3'd0, 3'd1));
      configure_run(iters, 1);
      load_samples();
      // 18 compute cycles so still running here
      apb_read(A_STATUS, rd, err);
      check_word("STATUS busy during run", rd[0], 1);
      run_model(iters, 1);
      collect_output();
      exp_re = samples[0].re + 16'(iters * samples[1].re);
      exp_im = samples[0].im + 16'(iters * samples[1].im);
      check_word("accumulated r0", out_words[0], {exp_re, exp_im});
      check_outputs("accumulate");
      apb_read(A_STATUS, rd, err);
      check_word("STATUS after run", rd, {16'd0, 8'(runs_done), 8'd0});
   endtask

   task automatic busy_write_lockout();
      logic [31:0] rd;
      logic        err;
      random_samples();
      write_program(0, encode_instr(pe_pkg::OP_SUB, 3'd1, 3'd1, 3'd0));
      write_program(1, encode_instr(pe_pkg::OP_ADD, 3'd2, 3'd2, 3'd3));
      configure_run(20, 2);
      load_samples();
      // 80 compute cycles leave room for both writes
      apb_write(A_ITER, 32'd3, err);
      check_word("pslverr ITER write while busy", err, 1);
      apb_write(A_PROG, encode_instr(pe_pkg::OP_NOP, 3'd0, 3'd0, 3'd0), err);
      check_word("pslverr prog write while busy", err, 1);
      run_model(20, 2);
      collect_output();
      check_outputs("lockout");
      apb_read(A_ITER, rd, err);
      check_word("ITER kept after rejected write", rd, 20);
      apb_read(A_PROG, rd, err);
      check_word("prog[0] kept after rejected write", rd, {20'd0, prog_copy[0]});
      // empty program gives the samples straight back
      configure_run(20, 0);
      random_samples();
      load_samples();
      collect_output();
      check_outputs("empty program");
   endtask

   //////////////////////////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      seed      = 32'h4bc734a9;
      errors    = 0;
      checks    = 0;
      runs_done = 0;
      rst       = 1'b1;
      apb_req   = '0;
      din_v     = 1'b0;
      din       = '0;
      repeat (10) @(negedge clk);
      rst = 1'b0;

      reset_and_register_access();
      basic_alu_program();
      multiply_corners();
      repeated_accumulate();
      busy_write_lockout();

      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// File: pe_top.f
src/pe_pkg.sv
src/data_mem.sv
src/complex_alu.sv
src/pe_seq.sv
src/pe.sv
src/pe_config.sv
src/pe_top.sv
dv/tb_pe_top.sv

// File: src/complex_alu.sv
module complex_alu (
   input  logic            clk,
   input  logic            rst,
   input  logic            en,
   input  pe_pkg::opcode_t opcode,
   input  pe_pkg::cplx_t   a,
   input  pe_pkg::cplx_t   b,
   output pe_pkg::cplx_t   result,
   output logic            result_we
);

   // full precision partial products, 33 bits holds the sum of two
   logic signed [32:0] p_rr;
   logic signed [32:0] p_ii;
   logic signed [32:0] p_ri;
   logic signed [32:0] p_ir;
   logic signed [32:0] mul_re;
   logic signed [32:0] mul_im;
   logic signed [32:0] sh_re;
   logic signed [32:0] sh_im;
   logic               op_valid;

   ///////////////////////////////////////////////////////////////////////
   // multiply datapath
   ///////////////////////////////////////////////////////////////////////

   always_comb begin
      p_rr   = a.re * b.re;
      p_ii   = a.im * b.im;
      p_ri   = a.re * b.im;
      p_ir   = a.im * b.re;
      mul_re = p_rr - p_ii;
      mul_im = p_ri + p_ir;
      // arithmetic shift then keep low 16
      sh_re  = mul_re >>> pe_pkg::FRAC_BITS;
      sh_im  = mul_im >>> pe_pkg::FRAC_BITS;
   end

   // nop and unused codes write nothing
   assign op_valid = (opcode == pe_pkg::OP_MOV) || (opcode == pe_pkg::OP_ADD) ||
                     (opcode == pe_pkg::OP_SUB) || (opcode == pe_pkg::OP_MUL);

   // write flag, one cycle after issue
   always_ff @(posedge clk) begin
      if (rst) begin
         result_we <= 1'b0;
      end else begin
         result_we <= en && op_valid;
      end
   end

   // result register, add and sub wrap at 16 bits
   always_ff @(posedge clk) begin
      if (en) begin
         case (opcode)
            pe_pkg::OP_MOV: result <= a;
            pe_pkg::OP_ADD: begin
               result.re <= a.re + b.re;
               result.im <= a.im + b.im;
            end
            pe_pkg::OP_SUB: begin
               result.re <= a.re - b.re;
               result.im <= a.im - b.im;
            end
            pe_pkg::OP_MUL: begin
               result.re <= sh_re[15:0];
               result.im <= sh_im[15:0];
            end
            default: result <= result;
         endcase
      end
   end

endmodule

// File: src/data_mem.sv
module data_mem #(
   parameter int REG_NUM = 8
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             we,
   input  pe_pkg::reg_idx_t waddr,
   input  pe_pkg::cplx_t    wdata,
   input  pe_pkg::reg_idx_t raddr_a,
   input  pe_pkg::reg_idx_t raddr_b,
   output pe_pkg::cplx_t    rdata_a,
   output pe_pkg::cplx_t    rdata_b
);

   ///////////////////////////////////////////////////////////////////////
   // complex register file
   ///////////////////////////////////////////////////////////////////////

   pe_pkg::cplx_t regs [REG_NUM];

   // single write port, whole file zeroed on reset
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < REG_NUM; i++) begin
            regs[i] <= '0;
         end
      end else if (we) begin
         regs[waddr] <= wdata;
      end
   end

   // async reads
   // port a serves operand a and the output stream
   assign rdata_a = regs[raddr_a];
   // port b only ever operand b
   assign rdata_b = regs[raddr_b];

endmodule

// File: src/pe.sv
module pe #(
   parameter int REG_NUM = 8,
   parameter int OUT_NUM = 4
) (
   input  logic            clk,
   input  logic            rst,
   input  logic            din_v,
   input  pe_pkg::cplx_t   din,
   input  pe_pkg::pe_cfg_t cfg,
   input  pe_pkg::instr_t  instr,
   output pe_pkg::pc_t     pc,
   output logic            busy,
   output logic            done,
   output logic            dout_v,
   output pe_pkg::cplx_t   dout
);

   logic             load_we;
   pe_pkg::reg_idx_t load_idx;
   logic             issue;
   logic             wb;
   logic             out_en;
   pe_pkg::reg_idx_t out_idx;

   logic             mem_we;
   pe_pkg::reg_idx_t mem_waddr;
   pe_pkg::cplx_t    mem_wdata;
   pe_pkg::reg_idx_t raddr_a;
   pe_pkg::cplx_t    rdata_a;
   pe_pkg::cplx_t    rdata_b;
   pe_pkg::cplx_t    alu_result;
   logic             alu_we;

   pe_seq #(
      .REG_NUM (REG_NUM),
      .OUT_NUM (OUT_NUM)
   ) u_seq (
      .clk      (clk),
      .rst      (rst),
      .din_v    (din_v),
      .cfg      (cfg),
      .pc       (pc),
      .busy     (busy),
      .done     (done),
      .load_we  (load_we),
      .load_idx (load_idx),
      .issue    (issue),
      .wb       (wb),
      .out_en   (out_en),
      .out_idx  (out_idx)
   );

   ///////////////////////////////////////////////////////////////////////
   // register file port steering
   ///////////////////////////////////////////////////////////////////////

   // load and writeback never overlap, load wins anyway
   assign mem_we    = load_we || (wb && alu_we);
   assign mem_waddr = load_we ? load_idx : instr.dst;
   assign mem_wdata = load_we ? din : alu_result;
   // port a is shared with the output stream
   assign raddr_a   = out_en ? out_idx : instr.src_a;

   data_mem #(
      .REG_NUM (REG_NUM)
   ) u_mem (
      .clk     (clk),
      .rst     (rst),
      .we      (mem_we),
      .waddr   (mem_waddr),
      .wdata   (mem_wdata),
      .raddr_a (raddr_a),
      .raddr_b (instr.src_b),
      .rdata_a (rdata_a),
      .rdata_b (rdata_b)
   );

   complex_alu u_alu (
      .clk       (clk),
      .rst       (rst),
      .en        (issue),
      .opcode    (instr.opcode),
      .a         (rdata_a),
      .b         (rdata_b),
      .result    (alu_result),
      .result_we (alu_we)
   );

   // output stream, one cycle behind out_en
   always_ff @(posedge clk) begin
      if (rst) begin
         dout_v <= 1'b0;
      end else begin
         dout_v <= out_en;
      end
   end

   always_ff @(posedge clk) begin
      if (out_en) begin
         dout <= rdata_a;
      end
   end

endmodule

// File: src/pe_config.sv
module pe_config (
   input  logic             clk,
   input  logic             rst,
   input  pe_pkg::apb_req_t apb_req,
   output pe_pkg::apb_rsp_t apb_rsp,
   input  logic             busy,
   input  logic             done,
   input  pe_pkg::pc_t      pc,
   output pe_pkg::pe_cfg_t  cfg,
   output pe_pkg::instr_t   instr
);

   // program store, sixteen words
   pe_pkg::instr_t prog [16];
   logic [7:0]     done_count;

   logic        access;
   logic        is_iter;
   logic        is_icnt;
   logic        is_stat;
   logic        is_prog;
   logic        mapped;
   logic        err;
   logic        wr_en;
   pe_pkg::pc_t prog_idx;

   ///////////////////////////////////////////////////////////////////////
   // address decode
   ///////////////////////////////////////////////////////////////////////

   assign access   = apb_req.psel && apb_req.penable;
   assign is_iter  = (apb_req.paddr == pe_pkg::ADDR_ITER);
   assign is_icnt  = (apb_req.paddr == pe_pkg::ADDR_ICNT);
   assign is_stat  = (apb_req.paddr == pe_pkg::ADDR_STATUS);
   // 0x40 to 0x7c, word aligned
   assign is_prog  = (apb_req.paddr[7:6] == 2'b01) && (apb_req.paddr[1:0] == 2'b00);
   assign mapped   = is_iter || is_icnt || is_stat || is_prog;
   assign prog_idx = apb_req.paddr[5:2];

   // bad address, write while running, write to status
   assign err   = access && (!mapped || (apb_req.pwrite && (busy || is_stat)));
   assign wr_en = access && apb_req.pwrite && !err;

   // config registers
   always_ff @(posedge clk) begin
      if (rst) begin
         cfg <= '0;
      end else if (wr_en && is_iter) begin
         cfg.iter_count <= apb_req.pwdata[7:0];
      end else if (wr_en && is_icnt) begin
         // sixteen is the program depth, larger values saturate
         cfg.inst_count <= (apb_req.pwdata > 32'd16) ? 5'd16 : apb_req.pwdata[4:0];
      end
   end

   // program words
   always_ff @(posedge clk) begin
      if (wr_en && is_prog) begin
         prog[prog_idx] <= pe_pkg::instr_t'(apb_req.pwdata[11:0]);
      end
   end

   // completed runs, wraps
   always_ff @(posedge clk) begin
      if (rst) begin
         done_count <= '0;
      end else if (done) begin
         done_count <= done_count + 8'd1;
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // read path
   ///////////////////////////////////////////////////////////////////////

   always_comb begin
      apb_rsp         = '0;
      apb_rsp.pready  = 1'b1;
      apb_rsp.pslverr = err;
      if (is_iter) begin
         apb_rsp.prdata[7:0] = cfg.iter_count;
      end else if (is_icnt) begin
         apb_rsp.prdata[4:0] = cfg.inst_count;
      end else if (is_stat) begin
         apb_rsp.prdata[0]    = busy;
         apb_rsp.prdata[15:8] = done_count;
      end else if (is_prog) begin
         apb_rsp.prdata[11:0] = prog[prog_idx];
      end
   end

   // instruction fetch, no latency
   assign instr = prog[pc];

endmodule

// File: src/pe_pkg.sv
package pe_pkg;

   ///////////////////////////////////////////////////////////////////////
   // data types
   ///////////////////////////////////////////////////////////////////////

   // one real or imaginary component, Q1.15
   typedef logic signed [15:0] data_t;

   // one complex sample
   typedef struct packed {
      data_t re;
      data_t im;
   } cplx_t;

   typedef logic [2:0] reg_idx_t;
   typedef logic [3:0] pc_t;
   typedef logic [2:0] opcode_t;
   typedef logic [7:0] iter_t;
   // 0 to 16 instructions
   typedef logic [4:0] icnt_t;

   // opcodes, 5 to 7 act as nop
   localparam opcode_t OP_NOP = 3'd0;
   localparam opcode_t OP_MOV = 3'd1;
   localparam opcode_t OP_ADD = 3'd2;
   localparam opcode_t OP_SUB = 3'd3;
   localparam opcode_t OP_MUL = 3'd4;

   // shift after multiply
   localparam int FRAC_BITS = 15;

   // low 12 bits of a program word
   typedef struct packed {
      opcode_t  opcode;
      reg_idx_t dst;
      reg_idx_t src_a;
      reg_idx_t src_b;
   } instr_t;

   // run configuration handed to the element
   typedef struct packed {
      iter_t iter_count;
      icnt_t inst_count;
   } pe_cfg_t;

   ///////////////////////////////////////////////////////////////////////
   // APB
   ///////////////////////////////////////////////////////////////////////

   typedef logic [7:0]  apb_addr_t;
   typedef logic [31:0] apb_data_t;

   typedef struct packed {
      logic      psel;
      logic      penable;
      logic      pwrite;
      apb_addr_t paddr;
      apb_data_t pwdata;
   } apb_req_t;

   typedef struct packed {
      apb_data_t prdata;
      logic      pready;
      logic      pslverr;
   } apb_rsp_t;

   // register map
   localparam apb_addr_t ADDR_ITER   = 8'h00;
   localparam apb_addr_t ADDR_ICNT   = 8'h04;
   localparam apb_addr_t ADDR_STATUS = 8'h08;

endpackage

// File: src/pe_seq.sv
module pe_seq #(
   parameter int REG_NUM = 8,
   parameter int OUT_NUM = 4
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             din_v,
   input  pe_pkg::pe_cfg_t  cfg,
   output pe_pkg::pc_t      pc,
   output logic             busy,
   output logic             done,
   output logic             load_we,
   output pe_pkg::reg_idx_t load_idx,
   output logic             issue,
   output logic             wb,
   output logic             out_en,
   output pe_pkg::reg_idx_t out_idx
);

   typedef enum logic [1:0] {
      IDLE,
      LOAD,
      COMPUTE,
      OUTPUT
   } state_t;

   state_t           state;
   state_t           after_load;
   pe_pkg::reg_idx_t load_cnt;
   // 0 issue, 1 writeback
   logic             phase;
   pe_pkg::iter_t    iter_cnt;
   // one extra count so done lines up with the last registered output word
   logic [3:0]       out_cnt;
   logic             last_load;
   logic             last_inst;
   logic             last_iter;
   logic             out_last;

   // zero iterations or empty program go straight to output
   assign after_load = (cfg.iter_count == '0 || cfg.inst_count == '0) ? OUTPUT : COMPUTE;
   assign last_load  = (load_cnt == pe_pkg::reg_idx_t'(REG_NUM - 1));
   assign last_inst  = ({1'b0, pc} == cfg.inst_count - 5'd1);
   assign last_iter  = (iter_cnt == cfg.iter_count - 8'd1);
   assign out_last   = (out_cnt == 4'(OUT_NUM));

   ///////////////////////////////////////////////////////////////////////
   // state and counters
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= IDLE;
         load_cnt <= '0;
         pc       <= '0;
         phase    <= 1'b0;
         iter_cnt <= '0;
         out_cnt  <= '0;
      end else begin
         case (state)
            IDLE: begin
               // word 0 goes in here, LOAD picks up at 1
               load_cnt <= pe_pkg::reg_idx_t'(1);
               pc       <= '0;
               phase    <= 1'b0;
               iter_cnt <= '0;
               out_cnt  <= '0;
               if (din_v) begin
                  state <= (REG_NUM == 1) ? after_load : LOAD;
               end
            end
            LOAD: begin
               // gaps in din_v just hold
               if (din_v) begin
                  load_cnt <= load_cnt + 1'b1;
                  if (last_load) begin
                     state <= after_load;
                  end
               end
            end
            COMPUTE: begin
               phase <= ~phase;
               if (phase) begin
                  if (last_inst) begin
                     pc       <= '0;
                     iter_cnt <= iter_cnt + 1'b1;
                     if (last_iter) begin
                        state <= OUTPUT;
                     end
                  end else begin
                     pc <= pc + 1'b1;
                  end
               end
            end
            OUTPUT: begin
               out_cnt <= out_cnt + 1'b1;
               if (out_last) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // strobes
   assign busy     = (state != IDLE);
   assign load_we  = din_v && (state == IDLE || state == LOAD);
   assign load_idx = (state == LOAD) ? load_cnt : '0;
   assign issue    = (state == COMPUTE) && !phase;
   assign wb       = (state == COMPUTE) && phase;
   assign out_en   = (state == OUTPUT) && !out_last;
   assign out_idx  = pe_pkg::reg_idx_t'(out_cnt);
   assign done     = (state == OUTPUT) && out_last;

endmodule

// File: src/pe_top.sv
module pe_top #(
   parameter int REG_NUM = 8,
   parameter int OUT_NUM = 4
) (
   input  logic             clk,
   input  logic             rst,
   input  pe_pkg::apb_req_t apb_req,
   output pe_pkg::apb_rsp_t apb_rsp,
   input  logic             din_v,
   input  pe_pkg::cplx_t    din,
   output logic             dout_v,
   output pe_pkg::cplx_t    dout
);

   // config to element
   pe_pkg::pe_cfg_t cfg;
   pe_pkg::instr_t  instr;
   // element back to config
   pe_pkg::pc_t     pc;
   logic            busy;
   logic            done;

   ///////////////////////////////////////////////////////////////////////
   // APB register block
   ///////////////////////////////////////////////////////////////////////

   pe_config u_config (
      .clk     (clk),
      .rst     (rst),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp),
      .busy    (busy),
      .done    (done),
      .pc      (pc),
      .cfg     (cfg),
      .instr   (instr)
   );

   ///////////////////////////////////////////////////////////////////////
   // processing element
   ///////////////////////////////////////////////////////////////////////

   pe #(
      .REG_NUM (REG_NUM),
      .OUT_NUM (OUT_NUM)
   ) u_pe (
      .clk    (clk),
      .rst    (rst),
      .din_v  (din_v),
      .din    (din),
      .cfg    (cfg),
      .instr  (instr),
      .pc     (pc),
      .busy   (busy),
      .done   (done),
      .dout_v (dout_v),
      .dout   (dout)
   );

endmodule
